/* sources.f */
+incdir+design
design/frontend_pkg.sv
design/FetchUnit.sv
design/DecodeStage.sv
design/RenameUnit.sv
design/DispatchStage.sv
design/Processor.sv
test/RenameUnit_chk.sv
test/Processor_tb.sv

/* test/Processor_tb.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module Processor_tb import frontend_pkg::*; ();

  localparam int NUM_BUNDLES = 32;
  localparam int CYCLE_LIMIT = NUM_BUNDLES * 20 + 200;
  localparam logic [5:0] R_FUNCTS [6] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a};
  localparam logic [5:0] IMM_OPCODES [5] = '{6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e};

  logic         clk;
  logic         rstN;
  word_t        instAddress;
  word_t        inst1;
  word_t        inst2;
  word_t        inst3;
  word_t        inst4;
  logic         instMemReady;
  logic         instMemRead;
  logic         commitValid;
  physReg_t     commitPhy;
  issueBundle_t issueBundle;

  word_t    progMem [NUM_BUNDLES][`FETCH_WIDTH];
  physReg_t mapModel [`ARCH_REGS];
  physReg_t freeModel [$];
  physReg_t commitQueue [$];
  integer   seed;
  int       errors;
  int       checks;
  int       cycles;
  int       arrived;
  int       numExpected;
  int       nextBundle;
  word_t    expAddress;

  Processor DUT (
    .clk         (clk),
    .rstN        (rstN),
    .instAddress (instAddress),
    .inst1       (inst1),
    .inst2       (inst2),
    .inst3       (inst3),
    .inst4       (inst4),
    .instMemReady(instMemReady),
    .instMemRead (instMemRead),
    .commitValid (commitValid),
    .commitPhy   (commitPhy),
    .issueBundle (issueBundle)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Small register range so slots in one bundle collide
  function automatic word_t randomInstruction();
    logic [31:0] r;
    archReg_t    rs;
    archReg_t    rt;
    archReg_t    rd;
    int          kind;
    word_t       inst;

    r    = $random(seed);
    kind = {$random(seed)} % 10;
    rs   = archReg_t'(r[2:0]);
    rt   = archReg_t'(r[5:3]);
    rd   = archReg_t'(r[8:6]);
    if (kind < 5) begin
      inst = {6'h00, rs, rt, rd, 5'd0, R_FUNCTS[r[11:9] % 6]};
    end else if (kind < 8) begin
      inst = {IMM_OPCODES[r[11:9] % 5], rs, rt, r[27:12]};
    end else if (kind == 8) begin
      inst = r[12] ? {6'h23, rs, rt, r[27:12]} : {6'h00, rs, rt, rd, 5'd0, 6'h21};
    end else begin
      inst = {6'h00, rs, rt, 5'd0, 5'd0, R_FUNCTS[r[11:9] % 6]};
    end
    return inst;
  endfunction

  function automatic decodedSlot_t decodeModel(word_t w);
    decodedSlot_t s;

    s       = '0;
    s.valid = 1'b1;
    s.src1  = w[25:21];
    if (w[31:26] == 6'h00) begin
      s.src2 = w[20:16];
      s.rdst = w[15:11];
      case (w[5:0])
        6'h20: s.aluOp = {FUNC_RTYPE, ALU_ADD};
        6'h22: s.aluOp = {FUNC_RTYPE, ALU_SUB};
        6'h24: s.aluOp = {FUNC_RTYPE, ALU_AND};
        6'h25: s.aluOp = {FUNC_RTYPE, ALU_OR};
        6'h26: s.aluOp = {FUNC_RTYPE, ALU_XOR};
        6'h2a: s.aluOp = {FUNC_RTYPE, ALU_SLT};
        default: s.valid = 1'b0;
      endcase
    end else begin
      s.rdst = w[20:16];
      s.imm  = {16'h0000, w[15:0]};
      case (w[31:26])
        6'h08: s.aluOp = {FUNC_IMM, ALU_ADD};
        6'h0a: s.aluOp = {FUNC_IMM, ALU_SLT};
        6'h0c: s.aluOp = {FUNC_IMM, ALU_AND};
        6'h0d: s.aluOp = {FUNC_IMM, ALU_OR};
        6'h0e: s.aluOp = {FUNC_IMM, ALU_XOR};
        default: s.valid = 1'b0;
      endcase
      if (w[31:26] == 6'h08 || w[31:26] == 6'h0a) begin
        s.imm = {{16{w[15]}}, w[15:0]};
      end
    end
    s.regW = s.valid;
    if (!s.valid) begin
      s = '0;
    end
    return s;
  endfunction

  // Any slot of the bundle holds a supported instruction
  function automatic logic bundleHasValid(int b);
    decodedSlot_t d;
    logic         any;

    any = 1'b0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      d   = decodeModel(progMem[b][i]);
      any = any | d.valid;
    end
    return any;
  endfunction

  // Sequential rename gives in-bundle forwarding for free
  task automatic renameModel(input int b, output issueBundle_t exp, output logic anyValid);
    decodedSlot_t d;

    anyValid = 1'b0;
    exp      = '0;
    exp.pc   = word_t'(b * `PC_STEP);
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      d = decodeModel(progMem[b][i]);
      if (d.valid) begin
        anyValid                 = 1'b1;
        exp.slot[i].valid        = 1'b1;
        exp.slot[i].aluOp        = d.aluOp;
        exp.slot[i].imm          = d.imm;
        exp.slot[i].rdst         = d.rdst;
        exp.slot[i].physSrc1     = mapModel[d.src1];
        exp.slot[i].physSrc2     = mapModel[d.src2];
        if (d.rdst != '0) begin
          if (freeModel.size() == 0) begin
            errors++;
            $display("Free list model ran empty while renaming bundle %0d", b);
          end else begin
            exp.slot[i].phyDst = freeModel.pop_front();
            mapModel[d.rdst]   = exp.slot[i].phyDst;
          end
        end
      end
    end
  endtask

  task automatic checkField(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic checkIssue();
    issueBundle_t exp;
    logic         anyValid;
    logic         outValid;

    outValid = 1'b0;
    anyValid = 1'b0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      outValid = outValid | issueBundle.slot[i].valid;
    end
    if (!outValid) begin
      return;
    end
    while (!anyValid && nextBundle < NUM_BUNDLES) begin
      renameModel(nextBundle, exp, anyValid);
      nextBundle++;
    end
    if (!anyValid) begin
      errors++;
      $display("A bundle arrived on issueBundle after the last expected one");
      return;
    end
    arrived++;
    checkField("issueBundle.pc", exp.pc, issueBundle.pc);
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      checkField($sformatf("slot%0d.valid", i), exp.slot[i].valid, issueBundle.slot[i].valid);
      if (exp.slot[i].valid) begin
        checkField($sformatf("slot%0d.aluOp", i), exp.slot[i].aluOp, issueBundle.slot[i].aluOp);
        checkField($sformatf("slot%0d.imm", i), exp.slot[i].imm, issueBundle.slot[i].imm);
        checkField($sformatf("slot%0d.rdst", i), exp.slot[i].rdst, issueBundle.slot[i].rdst);
        checkField($sformatf("slot%0d.physSrc1", i), exp.slot[i].physSrc1,
                   issueBundle.slot[i].physSrc1);
        checkField($sformatf("slot%0d.physSrc2", i), exp.slot[i].physSrc2,
                   issueBundle.slot[i].physSrc2);
        checkField($sformatf("slot%0d.phyDst", i), exp.slot[i].phyDst,
                   issueBundle.slot[i].phyDst);
        if (exp.slot[i].rdst != '0) begin
          commitQueue.push_back(exp.slot[i].phyDst);
        end
      end
    end
  endtask

  // Memory answers the current PC and commits at most one register per cycle
  task automatic driveInputs();
    int idx;

    idx          = (instAddress / `PC_STEP) % NUM_BUNDLES;
    instMemReady = (instAddress < NUM_BUNDLES * `PC_STEP) && ({$random(seed)} % 5 != 0);
    inst1        = progMem[idx][0];
    inst2        = progMem[idx][1];
    inst3        = progMem[idx][2];
    inst4        = progMem[idx][3];
    expAddress   = instAddress + ((instMemReady && instMemRead) ? `PC_STEP : 0);
    if (commitQueue.size() > 8) begin
      commitValid = 1'b1;
      commitPhy   = commitQueue.pop_front();
      freeModel.push_back(commitPhy);
    end else begin
      commitValid = 1'b0;
    end
  endtask

  initial begin
    seed         = 32'hace1;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    arrived      = 0;
    numExpected  = 0;
    nextBundle   = 0;
    rstN         = 1'b0;
    instMemReady = 1'b0;
    inst1        = '0;
    inst2        = '0;
    inst3        = '0;
    inst4        = '0;
    commitValid  = 1'b0;
    commitPhy    = '0;
    for (int b = 0; b < NUM_BUNDLES; b++) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        progMem[b][i] = randomInstruction();
      end
    end
    // Bundles with no supported instruction never reach issue
    for (int b = 0; b < NUM_BUNDLES; b++) begin
      if (bundleHasValid(b)) begin
        numExpected++;
      end
    end
    for (int a = 0; a < `ARCH_REGS; a++) begin
      mapModel[a] = physReg_t'(a);
    end
    for (int f = 0; f < `PHYS_REGS - `ARCH_REGS; f++) begin
      freeModel.push_back(physReg_t'(`ARCH_REGS + f));
    end

    repeat (4) @(negedge clk);
    rstN = 1'b1;
    checkField("instMemRead", 1, instMemRead);
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      checkField($sformatf("slot%0d.valid", i), 0, issueBundle.slot[i].valid);
    end
    driveInputs();

    while (arrived < numExpected && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      cycles++;
      checkField("instAddress", expAddress, instAddress);
      checkIssue();
      driveInputs();
    end

    if (arrived < numExpected) begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d bundles received",
               cycles, arrived, numExpected);
    end else begin
      repeat (8) begin
        @(negedge clk);
        checkIssue();
        driveInputs();
      end
    end

    errors += DUT.renameUnit.chk.assertFailures;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.renameUnit.chk.assertFailures);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* test/RenameUnit_chk.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module RenameUnit_chk import frontend_pkg::*; (
  input logic                                       clk,
  input logic                                       rstN,
  input logic                                       frontStall,
  input logic [$clog2(`PHYS_REGS-`ARCH_REGS):0]     freeCount,
  input logic [$clog2(`PHYS_REGS-`ARCH_REGS)-1:0]   head,
  input renameBundle_t                              renamed
);

  int assertFailures = 0;

  function automatic logic distinctDestinations(renameBundle_t b);
    logic ok;
    logic wrI;
    logic wrJ;

    ok = 1'b1;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      for (int j = i + 1; j < `FETCH_WIDTH; j++) begin
        wrI = b.slot[i].valid & b.slot[i].regW & (b.slot[i].rdst != '0);
        wrJ = b.slot[j].valid & b.slot[j].regW & (b.slot[j].rdst != '0);
        if (wrI && wrJ && b.slot[i].phyDst == b.slot[j].phyDst) begin
          ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  freeCountBound: assert property (@(posedge clk) disable iff (!rstN)
    freeCount <= (`PHYS_REGS - `ARCH_REGS))
    else begin
      assertFailures++;
      $error("Free count %0d is larger than the free list", freeCount);
    end

  // Head pointer only moves on allocation
  stallNoAlloc: assert property (@(posedge clk) disable iff (!rstN)
    frontStall |=> $stable(head))
    else begin
      assertFailures++;
      $error("Free list head moved while rename was stalled");
    end

  uniqueDest: assert property (@(posedge clk) disable iff (!rstN)
    distinctDestinations(renamed))
    else begin
      assertFailures++;
      $error("Two writer slots of one bundle share a physical destination");
    end

endmodule

bind RenameUnit RenameUnit_chk chk (
  .clk       (clk),
  .rstN      (rstN),
  .frontStall(frontStall),
  .freeCount (freeCount),
  .head      (head),
  .renamed   (renamed)
);

/* design/Processor.sv */
`timescale 1ns/10ps

module Processor import frontend_pkg::*; (
  input  logic         clk,
  input  logic         rstN,
  // Instruction memory
  output word_t        instAddress,
  input  word_t        inst1,
  input  word_t        inst2,
  input  word_t        inst3,
  input  word_t        inst4,
  input  logic         instMemReady,
  output logic         instMemRead,
  // Commit refill of the free list
  input  logic         commitValid,
  input  physReg_t     commitPhy,
  output issueBundle_t issueBundle
);

  fetchBundle_t  fetched;
  decodeBundle_t decoded;
  renameBundle_t renamed;
  logic          frontStall;

  FetchUnit fetchUnit (
    .clk         (clk),
    .rstN        (rstN),
    .instMemReady(instMemReady),
    .inst1       (inst1),
    .inst2       (inst2),
    .inst3       (inst3),
    .inst4       (inst4),
    .frontStall  (frontStall),
    .instAddress (instAddress),
    .instMemRead (instMemRead),
    .fetched     (fetched)
  );

  DecodeStage decodeStage (
    .clk       (clk),
    .rstN      (rstN),
    .fetched   (fetched),
    .frontStall(frontStall),
    .decoded   (decoded)
  );

  // Only stall source left is running out of physical registers
  RenameUnit renameUnit (
    .clk        (clk),
    .rstN       (rstN),
    .decoded    (decoded),
    .commitValid(commitValid),
    .commitPhy  (commitPhy),
    .renamed    (renamed),
    .frontStall (frontStall)
  );

  DispatchStage dispatchStage (
    .clk        (clk),
    .rstN       (rstN),
    .renamed    (renamed),
    .issueBundle(issueBundle)
  );

endmodule

/* design/DispatchStage.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module DispatchStage import frontend_pkg::*; (
  input  logic          clk,
  input  logic          rstN,
  input  renameBundle_t renamed,
  output issueBundle_t  issueBundle
);

  issueBundle_t            nextBundle;
  issueBundle_t            bundleQ;
  logic [`FETCH_WIDTH-1:0] writer;
  logic [`FETCH_WIDTH-1:0] validQ;

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      writer[i] = renamed.slot[i].valid & renamed.slot[i].regW &
                  (renamed.slot[i].rdst != '0);
    end
  end

  // Nearest earlier writer in the bundle overrides the map value
  always_comb begin
    nextBundle.pc = renamed.pc;
    for (int j = 0; j < `FETCH_WIDTH; j++) begin
      nextBundle.slot[j].valid    = renamed.slot[j].valid;
      nextBundle.slot[j].aluOp    = renamed.slot[j].aluOp;
      nextBundle.slot[j].imm      = renamed.slot[j].imm;
      nextBundle.slot[j].rdst     = renamed.slot[j].rdst;
      nextBundle.slot[j].phyDst   = renamed.slot[j].phyDst;
      nextBundle.slot[j].physSrc1 = renamed.slot[j].physSrc1;
      nextBundle.slot[j].physSrc2 = renamed.slot[j].physSrc2;
      for (int i = 0; i < j; i++) begin
        if (writer[i] && renamed.slot[i].rdst == renamed.slot[j].src1) begin
          nextBundle.slot[j].physSrc1 = renamed.slot[i].phyDst;
        end
        if (writer[i] && renamed.slot[i].rdst == renamed.slot[j].src2) begin
          nextBundle.slot[j].physSrc2 = renamed.slot[i].phyDst;
        end
      end
    end
  end

  // DS/IS register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= '0;
    end else begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        validQ[i] <= nextBundle.slot[i].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    bundleQ <= nextBundle;
  end

  always_comb begin
    issueBundle = bundleQ;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      issueBundle.slot[i].valid = validQ[i];
    end
  end

endmodule

/* design/RenameUnit.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module RenameUnit import frontend_pkg::*; (
  input  logic          clk,
  input  logic          rstN,
  input  decodeBundle_t decoded,
  input  logic          commitValid,
  input  physReg_t      commitPhy,
  output renameBundle_t renamed,
  output logic          frontStall
);

  localparam int FREE_REGS = `PHYS_REGS - `ARCH_REGS;
  localparam int PTR_BITS  = $clog2(FREE_REGS);

  physReg_t                mapTable [`ARCH_REGS];
  physReg_t                freeList [FREE_REGS];
  logic [PTR_BITS-1:0]     head;
  logic [PTR_BITS-1:0]     tail;
  logic [PTR_BITS:0]       freeCount;
  logic [`FETCH_WIDTH-1:0] writer;
  logic [PTR_BITS:0]       numWriters;
  logic [PTR_BITS-1:0]     allocOffset [`FETCH_WIDTH];
  logic                    allocate;
  renameBundle_t           nextBundle;
  renameBundle_t           bundleQ;
  logic [`FETCH_WIDTH-1:0] validQ;

  // Writers to r0 take no register
  always_comb begin
    numWriters = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      writer[i] = decoded.slot[i].valid & decoded.slot[i].regW &
                  (decoded.slot[i].rdst != '0);
      allocOffset[i] = numWriters[PTR_BITS-1:0];
      if (writer[i]) begin
        numWriters = numWriters + 1'b1;
      end
    end
  end

  assign frontStall = freeCount < numWriters;
  assign allocate   = ~frontStall;

  // Sources see the map from before this bundle
  always_comb begin
    nextBundle.pc = decoded.pc;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      nextBundle.slot[i].valid    = decoded.slot[i].valid;
      nextBundle.slot[i].regW     = decoded.slot[i].regW;
      nextBundle.slot[i].aluOp    = decoded.slot[i].aluOp;
      nextBundle.slot[i].imm      = decoded.slot[i].imm;
      nextBundle.slot[i].rdst     = decoded.slot[i].rdst;
      nextBundle.slot[i].src1     = decoded.slot[i].src1;
      nextBundle.slot[i].src2     = decoded.slot[i].src2;
      nextBundle.slot[i].physSrc1 = mapTable[decoded.slot[i].src1];
      nextBundle.slot[i].physSrc2 = mapTable[decoded.slot[i].src2];
      if (writer[i]) begin
        nextBundle.slot[i].phyDst = freeList[head + allocOffset[i]];
      end else begin
        nextBundle.slot[i].phyDst = '0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int a = 0; a < `ARCH_REGS; a++) begin
        mapTable[a] <= physReg_t'(a);
      end
      for (int f = 0; f < FREE_REGS; f++) begin
        freeList[f] <= physReg_t'(`ARCH_REGS + f);
      end
      head      <= '0;
      tail      <= '0;
      freeCount <= (PTR_BITS + 1)'(FREE_REGS);
    end else begin
      if (allocate) begin
        // Later slot wins on the same rdst
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
          if (writer[i]) begin
            mapTable[decoded.slot[i].rdst] <= nextBundle.slot[i].phyDst;
          end
        end
        head <= head + numWriters[PTR_BITS-1:0];
      end
      if (commitValid) begin
        freeList[tail] <= commitPhy;
        tail           <= tail + 1'b1;
      end
      freeCount <= freeCount + commitValid - (allocate ? numWriters : '0);
    end
  end

  // RN/DS register, bubble while stalled
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= '0;
    end else begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        validQ[i] <= nextBundle.slot[i].valid & allocate;
      end
    end
  end

  always_ff @(posedge clk) begin
    bundleQ <= nextBundle;
  end

  always_comb begin
    renamed = bundleQ;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      renamed.slot[i].valid = validQ[i];
    end
  end

endmodule

/* design/DecodeStage.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module DecodeStage import frontend_pkg::*; (
  input  logic          clk,
  input  logic          rstN,
  input  fetchBundle_t  fetched,
  input  logic          frontStall,
  output decodeBundle_t decoded
);

  decodeBundle_t           nextBundle;
  decodeBundle_t           bundleQ;
  logic [`FETCH_WIDTH-1:0] validQ;

  // Integer ALU subset, anything else becomes an empty slot
  function automatic decodedSlot_t decodeWord(input logic fetchValid, input word_t inst);
    decodedSlot_t  slot;
    aluOperation_t op;
    logic [5:0]    opcode;
    logic [5:0]    funct;
    logic          known;
    logic          signExt;

    opcode  = inst[31:26];
    funct   = inst[5:0];
    op      = ALU_ADD;
    known   = 1'b1;
    signExt = 1'b0;
    slot    = '0;
    if (opcode == 6'h00) begin
      case (funct)
        6'h20: op = ALU_ADD;
        6'h22: op = ALU_SUB;
        6'h24: op = ALU_AND;
        6'h25: op = ALU_OR;
        6'h26: op = ALU_XOR;
        6'h2a: op = ALU_SLT;
        default: known = 1'b0;
      endcase
      slot.aluOp = {FUNC_RTYPE, op};
      slot.src1  = inst[25:21];
      slot.src2  = inst[20:16];
      slot.rdst  = inst[15:11];
    end else begin
      case (opcode)
        6'h08: begin
          op      = ALU_ADD;
          signExt = 1'b1;
        end
        6'h0a: begin
          op      = ALU_SLT;
          signExt = 1'b1;
        end
        6'h0c: op = ALU_AND;
        6'h0d: op = ALU_OR;
        6'h0e: op = ALU_XOR;
        default: known = 1'b0;
      endcase
      // Second source unused, stays r0
      slot.aluOp = {FUNC_IMM, op};
      slot.src1  = inst[25:21];
      slot.rdst  = inst[20:16];
      if (signExt) begin
        slot.imm = {{(`DATA_WIDTH-16){inst[15]}}, inst[15:0]};
      end else begin
        slot.imm = word_t'(inst[15:0]);
      end
    end
    slot.valid = known;
    slot.regW  = known;
    if (!(fetchValid && known)) begin
      slot = '0;
    end
    return slot;
  endfunction

  always_comb begin
    nextBundle.pc = fetched.pc;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      nextBundle.slot[i] = decodeWord(fetched.valid, fetched.inst[i]);
    end
  end

  // ID/RN register, held while rename is short of registers
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= '0;
    end else if (!frontStall) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        validQ[i] <= nextBundle.slot[i].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!frontStall) begin
      bundleQ <= nextBundle;
    end
  end

  always_comb begin
    decoded = bundleQ;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      decoded.slot[i].valid = validQ[i];
    end
  end

endmodule

/* design/FetchUnit.sv */
`timescale 1ns/10ps
`include "frontend_defines.svh"

module FetchUnit import frontend_pkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  logic         instMemReady,
  input  word_t        inst1,
  input  word_t        inst2,
  input  word_t        inst3,
  input  word_t        inst4,
  input  logic         frontStall,
  output word_t        instAddress,
  output logic         instMemRead,
  output fetchBundle_t fetched
);

  word_t                    pc;
  logic                     bundleValid;
  word_t                    bundlePc;
  word_t [`FETCH_WIDTH-1:0] bundleInst;
  logic                     accept;

  assign accept      = instMemReady & ~frontStall;
  assign instAddress = pc;
  assign instMemRead = ~frontStall;

  // Bubble when memory is not ready, hold everything on stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc          <= '0;
      bundleValid <= 1'b0;
    end else if (!frontStall) begin
      bundleValid <= instMemReady;
      if (instMemReady) begin
        pc <= pc + word_t'(`PC_STEP);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bundlePc   <= pc;
      bundleInst <= {inst4, inst3, inst2, inst1};
    end
  end

  always_comb begin
    fetched.valid = bundleValid;
    fetched.pc    = bundlePc;
    fetched.inst  = bundleInst;
  end

endmodule

/* design/frontend_pkg.sv */
`include "frontend_defines.svh"

package frontend_pkg;

  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [$clog2(`ARCH_REGS)-1:0] archReg_t;
  typedef logic [$clog2(`PHYS_REGS)-1:0] physReg_t;

  // Upper 4 bits function class, lower 5 bits operation
  typedef logic [8:0] aluOp_t;
  typedef logic [3:0] funcClass_t;

  localparam funcClass_t FUNC_RTYPE = 4'd0;
  localparam funcClass_t FUNC_IMM   = 4'd1;

  typedef enum logic [4:0] {
    ALU_ADD = 5'd0,
    ALU_SUB = 5'd1,
    ALU_AND = 5'd2,
    ALU_OR  = 5'd3,
    ALU_XOR = 5'd4,
    ALU_SLT = 5'd5
  } aluOperation_t;

  // inst[0] is the first slot in program order
  typedef struct packed {
    logic                     valid;
    word_t                    pc;
    word_t [`FETCH_WIDTH-1:0] inst;
  } fetchBundle_t;

  typedef struct packed {
    logic     valid;
    logic     regW;
    archReg_t src1;
    archReg_t src2;
    archReg_t rdst;
    aluOp_t   aluOp;
    word_t    imm;
  } decodedSlot_t;

  typedef struct packed {
    word_t                           pc;
    decodedSlot_t [`FETCH_WIDTH-1:0] slot;
  } decodeBundle_t;

  typedef struct packed {
    logic     valid;
    logic     regW;
    aluOp_t   aluOp;
    word_t    imm;
    archReg_t rdst;
    archReg_t src1;
    archReg_t src2;
    physReg_t physSrc1;
    physReg_t physSrc2;
    physReg_t phyDst;
  } renamedSlot_t;

  typedef struct packed {
    word_t                           pc;
    renamedSlot_t [`FETCH_WIDTH-1:0] slot;
  } renameBundle_t;

  typedef struct packed {
    logic     valid;
    aluOp_t   aluOp;
    word_t    imm;
    archReg_t rdst;
    physReg_t physSrc1;
    physReg_t physSrc2;
    physReg_t phyDst;
  } issueSlot_t;

  typedef struct packed {
    word_t                         pc;
    issueSlot_t [`FETCH_WIDTH-1:0] slot;
  } issueBundle_t;

endpackage

/* design/frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Instructions per fetch bundle
`define FETCH_WIDTH 4

// Instruction, address and immediate width
`define DATA_WIDTH 32

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// Bytes between consecutive bundles
`define PC_STEP 16

`endif
